// ==== Makefile ====
TOP = hisTopTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

sim:
	verilator --binary --assert --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Test FAILED" sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hisBuilderFSM.sv ====
`timescale 1ns/1ps

module hisBuilderFSM #(
    parameter int numSamples = 64
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              wrEn,
    input  hisPkg::stampT     data,
    input  logic              inWindow,
    input  hisPkg::binT       fineBin,
    input  hisPkg::stampT     windowStart,
    input  logic              peakDone,
    input  hisPkg::binT       peakBin,
    input  hisPkg::countT     peakCount,
    output logic              incEn,
    output hisPkg::binT       incBin,
    output logic              scanEn,
    output hisPkg::binT       scanBin,
    output logic              scanStart,
    output logic              scanValid,
    output hisPkg::binT       scanIdx,
    output logic              windowLoad,
    output logic              busy,
    output logic              resultValid,
    output hisPkg::hisResultT result
);
    import hisPkg::*;

    localparam int CNT_W    = $clog2(numSamples + 1);
    localparam int NUM_BINS = 1 << NB;
    // step 0 is scanStart, steps 1..NUM_BINS issue addresses
    localparam logic [NB:0] SCAN_END = (NB + 1)'(NUM_BINS + 1);

    typedef enum logic [1:0] {
        coarse,
        coarseScan,
        fine,
        fineScan
    } stateT;

    stateT            state;
    logic [CNT_W-1:0] sampleCnt;
    logic [NB:0]      scanStep;
    logic             accept;
    logic             lastSample;
    logic             resultDone;
    logic             scanValidQ;
    binT              scanIdxQ;
    binT              coarsePeakQ;

    assign busy       = (state == coarseScan) || (state == fineScan);
    assign accept     = wrEn && !busy;
    assign lastSample = (sampleCnt == CNT_W'(numSamples - 1));

    // coarse uses top stamp bits, fine only counts inside the window
    assign incEn  = accept && ((state == coarse) || inWindow);
    assign incBin = (state == coarse) ? data[NP-1 -: NB] : fineBin;

    assign scanStart = busy && (scanStep == '0);
    assign scanEn    = busy && (scanStep != '0) && (scanStep != SCAN_END);
    assign scanBin   = NB'(scanStep - 1'b1);

    assign windowLoad = (state == coarseScan) && peakDone;
    assign resultDone = (state == fineScan) && peakDone;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= coarse;
            sampleCnt <= '0;
        end else begin
            unique case (state)
                coarse, fine: begin
                    if (accept) begin
                        if (lastSample) begin
                            sampleCnt <= '0;
                            state     <= (state == coarse) ? coarseScan : fineScan;
                        end else begin
                            sampleCnt <= sampleCnt + 1'b1;
                        end
                    end
                end
                coarseScan: begin
                    if (peakDone) begin
                        state <= fine;
                    end
                end
                fineScan: begin
                    if (peakDone) begin
                        state <= coarse;
                    end
                end
            endcase
        end
    end

    // scan step counter, parks at SCAN_END until peakDone
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            scanStep    <= '0;
            scanValidQ  <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            if (!busy) begin
                scanStep <= '0;
            end else if (scanStep != SCAN_END) begin
                scanStep <= scanStep + 1'b1;
            end
            // valid lines up with the memory read latency
            scanValidQ  <= scanEn;
            resultValid <= resultDone;
        end
    end

    always_ff @(posedge clk) begin
        scanIdxQ <= scanBin;
        if (windowLoad) begin
            coarsePeakQ <= peakBin;
        end
        if (resultDone) begin
            result.coarsePeak <= coarsePeakQ;
            result.finePeak   <= peakBin;
            result.peakCount  <= peakCount;
            result.fineStamp  <= windowStart + stampT'(peakBin);
        end
    end

    assign scanValid = scanValidQ;
    assign scanIdx   = scanIdxQ;

    // one strobe per finished run
    resultSinglePulse: assert property (@(posedge clk) disable iff (!rstN)
        resultValid |=> !resultValid)
        else $error("hisBuilderFSM: resultValid held two cycles");

endmodule

// ==== hisPkg.sv ====
package hisPkg;

    // timestamp width from the TDC channel
    localparam int NP = 10;

    // bin index width, 32 bins per pass
    localparam int NB = 5;

    // per-bin counter width, saturating
    localparam int COUNT_W = 8;

    // coarse bin covers 2**SHIFT_C ticks
    localparam int SHIFT_C = NP - NB;

    // raw timestamp
    typedef logic [NP-1:0] stampT;

    // histogram bin address
    typedef logic [NB-1:0] binT;

    // histogram bin count
    typedef logic [COUNT_W-1:0] countT;

    // final two-pass result
    // fineStamp is window start plus fine peak offset
    typedef struct packed {
        binT   coarsePeak;
        binT   finePeak;
        countT peakCount;
        stampT fineStamp;
    } hisResultT;

endpackage

// ==== hisTop.sv ====
`timescale 1ns/1ps

module hisTop #(
    parameter int numSamples = 64
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              wrEn,
    input  hisPkg::stampT     data,
    output logic              busy,
    output logic              resultValid,
    output hisPkg::hisResultT result
);
    import hisPkg::*;

    // memory traffic
    logic  incEn;
    binT   incBin;
    logic  scanEn;
    binT   scanBin;
    countT scanCount;

    // peak search
    logic  scanStart;
    logic  scanValid;
    binT   scanIdx;
    logic  peakDone;
    binT   peakBin;
    countT peakCount;

    // fine window
    logic  windowLoad;
    logic  inWindow;
    binT   fineBin;
    stampT windowStart;

    hisBuilderFSM #(
        .numSamples(numSamples)
    ) fsm_i (
        .clk(clk),
        .rstN(rstN),
        .wrEn(wrEn),
        .data(data),
        .inWindow(inWindow),
        .fineBin(fineBin),
        .windowStart(windowStart),
        .peakDone(peakDone),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .incEn(incEn),
        .incBin(incBin),
        .scanEn(scanEn),
        .scanBin(scanBin),
        .scanStart(scanStart),
        .scanValid(scanValid),
        .scanIdx(scanIdx),
        .windowLoad(windowLoad),
        .busy(busy),
        .resultValid(resultValid),
        .result(result)
    );

    histogramRam ram_i (
        .clk(clk),
        .rstN(rstN),
        .incEn(incEn),
        .incBin(incBin),
        .scanEn(scanEn),
        .scanBin(scanBin),
        .scanCount(scanCount)
    );

    peakDetecter peak_i (
        .clk(clk),
        .rstN(rstN),
        .scanStart(scanStart),
        .scanValid(scanValid),
        .scanIdx(scanIdx),
        .scanCount(scanCount),
        .peakDone(peakDone),
        .peakBin(peakBin),
        .peakCount(peakCount)
    );

    // coarse peak feeds the window straight from the detector
    windowFilter window_i (
        .clk(clk),
        .rstN(rstN),
        .windowLoad(windowLoad),
        .coarsePeak(peakBin),
        .stamp(data),
        .inWindow(inWindow),
        .fineBin(fineBin),
        .windowStart(windowStart)
    );

endmodule

// ==== hisTopTb.sv ====
`timescale 1ns/1ps

module hisTopTb;
    import hisPkg::*;

    localparam int NUM_SAMPLES = 64;
    localparam int NUM_TESTS = 6;
    // last fine sample to resultValid
    localparam int LATENCY = 36;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (2 * NUM_SAMPLES + 2 * LATENCY + 10) + 200;
    // window geometry in ticks
    localparam int BIN_TICKS = 32;
    localparam int HALF_BIN = 16;
    localparam int START_MAX = 992;
    localparam int NUM_BINS = 32;
    localparam int MAX_COUNT = 255;

    logic      clk = 1'b0;
    logic      rstN;
    logic      wrEn;
    stampT     data;
    logic      busy;
    logic      resultValid;
    hisResultT result;

    // stamps for the pass under test
    stampT     coarseSet [NUM_SAMPLES];
    stampT     fineSet [NUM_SAMPLES];
    hisResultT expected;
    int        seed;
    int        testNum = 0;
    int        runsStarted = 0;
    int        resultCount = 0;
    int        errorCount = 0;
    int        cycleCnt = 0;
    int        lastAccept = 0;
    logic      rstLowLast = 1'b0;

    always #10 clk = ~clk;

    hisTop #(
        .numSamples(NUM_SAMPLES)
    ) dut_i (
        .clk(clk),
        .rstN(rstN),
        .wrEn(wrEn),
        .data(data),
        .busy(busy),
        .resultValid(resultValid),
        .result(result)
    );

    // both histograms rebuilt from the stored stamps
    function automatic hisResultT expectHis();
        int        coarseHist [NUM_BINS];
        int        fineHist [NUM_BINS];
        int        coarseBin;
        int        coarseMax;
        int        fineBin;
        int        fineMax;
        int        start;
        int        offs;
        hisResultT res;
        for (int b = 0; b < NUM_BINS; b++) begin
            coarseHist[b] = 0;
            fineHist[b] = 0;
        end
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            offs = int'(coarseSet[i]) / BIN_TICKS;
            if (coarseHist[offs] < MAX_COUNT) begin
                coarseHist[offs]++;
            end
        end
        // strictly greater wins, so ties keep the lower bin
        coarseBin = 0;
        coarseMax = 0;
        for (int b = 0; b < NUM_BINS; b++) begin
            if (coarseHist[b] > coarseMax) begin
                coarseBin = b;
                coarseMax = coarseHist[b];
            end
        end
        start = coarseBin * BIN_TICKS - HALF_BIN;
        if (start < 0) begin
            start = 0;
        end
        if (start > START_MAX) begin
            start = START_MAX;
        end
        // out of window stamps are dropped
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            offs = int'(fineSet[i]) - start;
            if (offs >= 0 && offs < BIN_TICKS && fineHist[offs] < MAX_COUNT) begin
                fineHist[offs]++;
            end
        end
        fineBin = 0;
        fineMax = 0;
        for (int b = 0; b < NUM_BINS; b++) begin
            if (fineHist[b] > fineMax) begin
                fineBin = b;
                fineMax = fineHist[b];
            end
        end
        res.coarsePeak = binT'(coarseBin);
        res.finePeak = binT'(fineBin);
        res.peakCount = countT'(fineMax);
        res.fineStamp = stampT'(start + fineBin);
        return res;
    endfunction

    task automatic checkBin(input string name, input binT got, input binT exp);
        if (got !== exp) begin
            errorCount++;
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input countT got, input countT exp);
        if (got !== exp) begin
            errorCount++;
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic checkStamp(input string name, input stampT got, input stampT exp);
        if (got !== exp) begin
            errorCount++;
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errorCount++;
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic checkResult(input hisResultT got, input hisResultT exp);
        checkBin("result.coarsePeak", got.coarsePeak, exp.coarsePeak);
        checkBin("result.finePeak", got.finePeak, exp.finePeak);
        checkCount("result.peakCount", got.peakCount, exp.peakCount);
        checkStamp("result.fineStamp", got.fineStamp, exp.fineStamp);
    endtask

    task automatic checkLatency(input int cycles);
        if (cycles != LATENCY) begin
            errorCount++;
            $display("FAIL latency got 0x%0h expected 0x%0h", cycles, LATENCY);
        end
    endtask

    // old values at the edge, DUT updates land later
    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (!rstN) begin
            // second reset edge, outputs must be cleared
            if (rstLowLast) begin
                checkFlag("busy", busy, 1'b0);
                checkFlag("resultValid", resultValid, 1'b0);
            end
            rstLowLast = 1'b1;
        end else begin
            rstLowLast = 1'b0;
            if (wrEn && !busy) begin
                lastAccept = cycleCnt;
            end
            if (resultValid) begin
                if (resultCount < runsStarted) begin
                    checkResult(result, expected);
                    checkLatency(cycleCnt - lastAccept);
                    resultCount++;
                end else begin
                    errorCount++;
                    $display("resultValid pulsed with no run in progress");
                end
            end
        end
    end

    always @(posedge clk) begin
        if (cycleCnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // spread is a power of two
    function automatic stampT drawNear(input int center, input int spread);
        int v;
        v = center - spread / 2 + ($random(seed) & (spread - 1));
        if (v < 0) begin
            v = 0;
        end
        if (v > 1023) begin
            v = 1023;
        end
        return stampT'(v);
    endfunction

    // cluster plus random background, first stamps repeat back to back
    task automatic fillCluster(input int coarseCenter, input int fineCenter);
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            if (i < 6) begin
                coarseSet[i] = stampT'(coarseCenter);
                fineSet[i] = stampT'(fineCenter);
            end else if (i % 4 == 3) begin
                coarseSet[i] = stampT'($random(seed));
                fineSet[i] = stampT'($random(seed));
            end else begin
                coarseSet[i] = drawNear(coarseCenter, 32);
                fineSet[i] = drawNear(fineCenter, 16);
            end
        end
    endtask

    // bins 20 and 10 tie, then fine offsets 12 and 5 tie
    task automatic fillTies();
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            if (i >= 60) begin
                coarseSet[i] = stampT'(97);
                fineSet[i] = stampT'(330);
            end else if (i % 2 == 0) begin
                coarseSet[i] = stampT'(645);
                fineSet[i] = stampT'(316);
            end else begin
                coarseSet[i] = stampT'(327);
                fineSet[i] = stampT'(309);
            end
        end
    endtask

    // top coarse bin, fine stamps below and above the window
    task automatic fillOutside();
        fillCluster(31 * BIN_TICKS + 16, 0);
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            if (i < 56) begin
                fineSet[i] = stampT'(($random(seed) & 511) + 300);
            end else begin
                fineSet[i] = stampT'(1010 + i - 56);
            end
        end
    endtask

    // one stamp per cycle, waits out busy
    task automatic sendPass(input bit isFine, input int count, input bit hold);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            while (busy) begin
                wrEn = hold;
                data = stampT'($random(seed));
                @(negedge clk);
            end
            wrEn = 1'b1;
            data = isFine ? fineSet[i] : coarseSet[i];
        end
    endtask

    task automatic waitResult(input bit hold, input int target);
        while (resultCount < target) begin
            @(negedge clk);
            if (busy && hold) begin
                wrEn = 1'b1;
                data = stampT'($random(seed));
            end else begin
                wrEn = 1'b0;
            end
        end
        wrEn = 1'b0;
    endtask

    task automatic runTest(input string name, input bit hold);
        int errorsBefore;
        errorsBefore = errorCount;
        testNum++;
        expected = expectHis();
        runsStarted++;
        sendPass(1'b0, NUM_SAMPLES, hold);
        sendPass(1'b1, NUM_SAMPLES, hold);
        waitResult(hold, runsStarted);
        $display("test %0d %s: %s", testNum, name, (errorCount == errorsBefore) ? "pass" : "fail");
    endtask

    task automatic applyReset();
        @(negedge clk);
        rstN = 1'b0;
        wrEn = 1'b0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
    endtask

    initial begin
        seed = 43322;
        rstN = 1'b0;
        wrEn = 1'b0;
        data = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        fillCluster(9 * BIN_TICKS + 16, 9 * BIN_TICKS);
        runTest("cluster with background", 1'b0);

        fillTies();
        runTest("tied bins", 1'b0);

        fillCluster(16, 8);
        runTest("peak at bin 0", 1'b0);

        fillOutside();
        runTest("fine stamps outside window", 1'b0);

        fillCluster(22 * BIN_TICKS + 16, 22 * BIN_TICKS);
        runTest("wrEn held while busy", 1'b1);

        // full coarse pass into bin 25, reset part way into its scan
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            coarseSet[i] = stampT'(25 * BIN_TICKS + 3);
        end
        sendPass(1'b0, NUM_SAMPLES, 1'b0);
        @(negedge clk);
        wrEn = 1'b0;
        // bin 25 not yet read back, so it still holds its counts
        repeat (8) @(negedge clk);
        checkFlag("busy", busy, 1'b1);
        applyReset();
        fillCluster(7 * BIN_TICKS + 16, 7 * BIN_TICKS);
        runTest("reset mid pass", 1'b0);

        $display("%0d tests, %0d results checked, %0d errors", testNum, resultCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== histogramRam.sv ====
`timescale 1ns/1ps

module histogramRam (
    input  logic          clk,
    input  logic          rstN,
    input  logic          incEn,
    input  hisPkg::binT   incBin,
    input  logic          scanEn,
    input  hisPkg::binT   scanBin,
    output hisPkg::countT scanCount
);
    import hisPkg::*;

    localparam int NUM_BINS = 1 << NB;

    countT binMem [NUM_BINS];

    // pending increment, applied one cycle after the request
    logic  pendEn;
    binT   pendBin;
    countT pendOld;
    countT pendNew;
    countT scanCountQ;

    // saturating add
    assign pendNew = (pendOld == '1) ? pendOld : pendOld + countT'(1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pendEn <= 1'b0;
        end else begin
            pendEn <= incEn;
        end
    end

    always_ff @(posedge clk) begin
        pendBin <= incBin;
        // same bin back to back, take the value being written now
        if (pendEn && pendBin == incBin) begin
            pendOld <= pendNew;
        end else begin
            pendOld <= binMem[incBin];
        end
    end

    // count array, cleared on reset and by the scan
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_BINS; i++) begin
                binMem[i] <= '0;
            end
        end else begin
            if (pendEn) begin
                binMem[pendBin] <= pendNew;
            end
            // clear after read, wins over a late increment
            if (scanEn) begin
                binMem[scanBin] <= '0;
            end
        end
    end

    // scan read, one cycle latency
    always_ff @(posedge clk) begin
        if (pendEn && pendBin == scanBin) begin
            scanCountQ <= pendNew;
        end else begin
            scanCountQ <= binMem[scanBin];
        end
    end

    assign scanCount = scanCountQ;

    // FSM must keep sampling and scanning apart
    incScanExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(incEn && scanEn))
        else $error("histogramRam: increment during scan");

endmodule

// ==== peakDetecter.sv ====
`timescale 1ns/1ps

module peakDetecter (
    input  logic          clk,
    input  logic          rstN,
    input  logic          scanStart,
    input  logic          scanValid,
    input  hisPkg::binT   scanIdx,
    input  hisPkg::countT scanCount,
    output logic          peakDone,
    output hisPkg::binT   peakBin,
    output hisPkg::countT peakCount
);
    import hisPkg::*;

    // running maximum
    binT   maxBin;
    countT maxCount;
    logic  doneQ;
    logic  lastIdx;

    // all ones marks the final bin of the sweep
    assign lastIdx = scanValid && (scanIdx == '1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            maxBin   <= '0;
            maxCount <= '0;
            doneQ    <= 1'b0;
        end else begin
            doneQ <= lastIdx;
            if (scanStart) begin
                // new sweep starts from bin 0, count 0
                maxBin   <= '0;
                maxCount <= '0;
            end else if (scanValid && scanCount > maxCount) begin
                // strictly greater only, ties stay on the lower bin
                maxBin   <= scanIdx;
                maxCount <= scanCount;
            end
        end
    end

    assign peakDone  = doneQ;
    assign peakBin   = maxBin;
    assign peakCount = maxCount;

    // sweep from the FSM must run upward
    scanAscending: assert property (@(posedge clk) disable iff (!rstN)
        scanValid ##1 scanValid |-> scanIdx > $past(scanIdx))
        else $error("peakDetecter: scan index out of order");

endmodule

// ==== sim.f ====
hisPkg.sv
histogramRam.sv
peakDetecter.sv
windowFilter.sv
hisBuilderFSM.sv
hisTop.sv
hisTopTb.sv

// ==== windowFilter.sv ====
`timescale 1ns/1ps

module windowFilter (
    input  logic          clk,
    input  logic          rstN,
    input  logic          windowLoad,
    input  hisPkg::binT   coarsePeak,
    input  hisPkg::stampT stamp,
    output logic          inWindow,
    output hisPkg::binT   fineBin,
    output hisPkg::stampT windowStart
);
    import hisPkg::*;

    // half a coarse bin, window centred on the peak bin start
    localparam stampT HALF_BIN = stampT'(1 << (SHIFT_C - 1));
    // highest start that keeps the 32-tick window inside range
    localparam stampT START_MAX = stampT'((1 << NP) - (1 << NB));
    localparam stampT WIN_TICKS = stampT'(1 << NB);

    stampT baseTicks;
    stampT startNext;
    stampT startQ;
    stampT offset;

    // coarse peak times bin width
    assign baseTicks = {coarsePeak, {SHIFT_C{1'b0}}};

    always_comb begin
        if (baseTicks < HALF_BIN) begin
            // clamp at bottom
            startNext = '0;
        end else if (baseTicks - HALF_BIN > START_MAX) begin
            startNext = START_MAX;
        end else begin
            startNext = baseTicks - HALF_BIN;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            startQ <= '0;
        end else if (windowLoad) begin
            startQ <= startNext;
        end
    end

    // offset into window, wraps when below start
    assign offset      = stamp - startQ;
    assign inWindow    = (stamp >= startQ) && (offset < WIN_TICKS);
    assign fineBin     = offset[NB-1:0];
    assign windowStart = startQ;

endmodule
